// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module uart_tb -o uart_sim &&
./obj_dir/uart_sim | tee /dev/stderr | grep -q "All tests passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/uart_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_assert (
    input logic                clk,
    input logic                reset,
    input logic                tx_req,
    input logic                tx_ack,
    input logic [7:0]          tx_data,
    input logic                rx_req,
    input logic                rx_ack,
    input logic                txd,
    input uart_pkg::tx_state_t tx_state    // Transmitter FSM state
);

    // Ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(tx_ack) |-> $past(tx_req))
        else $error("tx_ack rose without tx_req");

    // Word offered until the host takes it
    rx_req_holds: assert property (@(posedge clk) disable iff (reset)
        rx_req && !rx_ack |=> rx_req)
        else $error("rx_req fell before rx_ack");

    // Host keeps the byte steady while waiting for ack
    tx_data_stable: assert property (@(posedge clk) disable iff (reset)
        tx_req && !tx_ack |=> $stable(tx_data))
        else $error("tx_data changed while request pending");

    // Line idles high outside a frame
    txd_idle_high: assert property (@(posedge clk) disable iff (reset)
        (tx_state == uart_pkg::TX_IDLE || tx_state == uart_pkg::TX_DISABLED) |-> txd)
        else $error("txd low while transmitter idle");

endmodule

bind uart_top uart_assert uart_assert_inst (
    .clk      (clk),
    .reset    (reset),
    .tx_req   (tx_req),
    .tx_ack   (tx_ack),
    .tx_data  (tx_data),
    .rx_req   (rx_req),
    .rx_ack   (rx_ack),
    .txd      (txd),
    .tx_state (uart_tx_inst.state)
);

`default_nettype wire

// ==== sim/uart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

    localparam int unsigned FAST_SEL = 7;               // 32 clocks per bit
    localparam int unsigned SLOW_SEL = 6;               // Slowest select used here
    localparam int unsigned N_FAST   = 8;               // Loopback frames at the fast rate
    localparam int unsigned N_SLOW   = 2;
    localparam int unsigned N_FRAMES = N_FAST + N_SLOW + 4;   // Plus injected and enable frames
    // All frames at the slowest rate, doubled, plus margin
    localparam int unsigned WATCHDOG_CYCLES =
        N_FRAMES * 11 * uart_pkg::OVERSAMPLE * uart_pkg::BAUD_DIV[SLOW_SEL] * 2 + 5000;

    logic                clk;
    logic                reset;
    uart_pkg::baud_sel_t baud_sel;
    logic                enable;
    logic                tx_req;
    logic [7:0]          tx_data;
    logic                tx_ack;
    logic                txd;
    logic                rxd;
    logic                rx_req;
    logic                rx_ack;
    uart_pkg::rx_word_t  rx_word;

    logic                loopback;                      // 1 routes txd back to rxd
    logic                inj_line;                      // Level of a hand-built frame
    int                  host_delay;                    // Cycles before rx_ack
    int unsigned         errors;
    int unsigned         checks;
    uart_pkg::rx_word_t  rx_q[$];                       // Words taken by the host
    uart_pkg::rx_word_t  w;
    logic [7:0]          data;

    uart_top uart_top_inst (
        .clk      (clk),
        .reset    (reset),
        .baud_sel (baud_sel),
        .enable   (enable),
        .tx_req   (tx_req),
        .tx_data  (tx_data),
        .tx_ack   (tx_ack),
        .txd      (txd),
        .rxd      (rxd),
        .rx_req   (rx_req),
        .rx_ack   (rx_ack),
        .rx_word  (rx_word)
    );

    assign rxd = loopback ? txd : inj_line;             // Line select

    initial clk = 1'b0;
    always #20 clk = ~clk;                              // 40 ns period

    task automatic check_cond(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("mismatch at %0t ns: %s", $time, msg);
        end
    endtask

    function automatic int unsigned bit_clocks();
        return uart_pkg::OVERSAMPLE * uart_pkg::BAUD_DIV[baud_sel];
    endfunction

    // Host side of the receive handshake
    initial begin
        rx_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (rx_req) begin
                for (int i = 0; i < host_delay; i++) begin
                    check_cond(rx_req, "rx_req dropped before rx_ack");
                    @(negedge clk);
                end
                rx_q.push_back(rx_word);                // Word is stable while rx_req
                rx_ack = 1'b1;
                while (rx_req)
                    @(negedge clk);
                rx_ack = 1'b0;                          // Close the four phases
            end
        end
    end

    task automatic wait_word(output uart_pkg::rx_word_t word);
        while (rx_q.size() == 0)
            @(negedge clk);
        word = rx_q.pop_front();
    endtask

    task automatic send_byte(input logic [7:0] byte_in);
        @(negedge clk);
        tx_data = byte_in;
        tx_req  = 1'b1;
        while (!tx_ack)
            @(negedge clk);
        tx_req = 1'b0;
        while (tx_ack)
            @(negedge clk);                             // Ack low before next request
    endtask

    // Samples txd at each bit midpoint, measured from the start edge
    task automatic check_frame(input logic [7:0] byte_in);
        logic [10:0] bits;
        int unsigned clks;
        bits = {1'b0, byte_in, ^byte_in, 1'b1};         // Start, MSB first, parity, stop
        clks = bit_clocks();
        @(negedge txd);
        repeat (clks / 2) @(negedge clk);
        for (int i = 0; i < 11; i++) begin
            check_cond(txd == bits[10],
                       $sformatf("frame bit %0d of %h is %b", i, byte_in, txd));
            bits = bits << 1;
            if (i < 10)
                repeat (clks) @(negedge clk);
        end
    endtask

    task automatic compare_word(input uart_pkg::rx_word_t word, input logic [7:0] exp_data,
                                input logic exp_perr, input logic exp_ferr);
        check_cond(word.data == exp_data,
                   $sformatf("rx byte %h, expected %h", word.data, exp_data));
        check_cond(word.parity_err == exp_perr,
                   $sformatf("parity_err %b for %h, expected %b",
                             word.parity_err, exp_data, exp_perr));
        check_cond(word.frame_err == exp_ferr,
                   $sformatf("frame_err %b for %h, expected %b",
                             word.frame_err, exp_data, exp_ferr));
    endtask

    task automatic loopback_byte(input logic [7:0] byte_in);
        uart_pkg::rx_word_t word;
        fork
            send_byte(byte_in);
            check_frame(byte_in);
        join
        wait_word(word);
        compare_word(word, byte_in, 1'b0, 1'b0);
    endtask

    // Hand-built frame on rxd with a chosen parity and stop bit
    task automatic drive_frame(input logic [7:0] byte_in, input logic parity, input logic stop);
        logic [10:0] bits;
        int unsigned clks;
        bits = {1'b0, byte_in, parity, stop};
        clks = bit_clocks();
        @(negedge clk);
        for (int i = 0; i < 11; i++) begin
            inj_line = bits[10];
            bits = bits << 1;
            repeat (clks) @(negedge clk);
        end
        inj_line = 1'b1;                                // Back to idle
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: no progress after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(72830));
        reset      = 1'b1;
        baud_sel   = 3'(FAST_SEL);
        enable     = 1'b1;
        tx_req     = 1'b0;
        tx_data    = 8'h00;
        loopback   = 1'b1;
        inj_line   = 1'b1;
        host_delay = 2;
        errors     = 0;
        checks     = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_cond(txd == 1'b1, "txd not high after reset");
        check_cond(!tx_ack && !rx_req, "handshake outputs not low after reset");

        for (int i = 0; i < N_FAST; i++)
            loopback_byte(8'($urandom));
        baud_sel = 3'(SLOW_SEL);                        // Rate switch between frames
        for (int i = 0; i < N_SLOW; i++)
            loopback_byte(8'($urandom));
        baud_sel = 3'(FAST_SEL);

        loopback = 1'b0;                                // Error injection
        host_delay = 40;                                // Slow host holds off rx_ack
        data = 8'($urandom);
        drive_frame(data, ~^data, 1'b1);
        wait_word(w);
        compare_word(w, data, 1'b1, 1'b0);
        data = 8'($urandom);
        drive_frame(data, ^data, 1'b0);
        wait_word(w);
        compare_word(w, data, 1'b0, 1'b1);
        loopback = 1'b1;

        // Enable dropped during a frame parks the transmitter in DISABLED after it
        data = 8'($urandom);
        @(negedge clk);
        tx_data = data;
        tx_req  = 1'b1;
        while (!tx_ack)
            @(negedge clk);
        enable = 1'b0;
        tx_req = 1'b0;
        wait_word(w);
        compare_word(w, data, 1'b0, 1'b0);
        repeat (2 * bit_clocks()) @(negedge clk);       // Stop bit done
        data = 8'($urandom);
        tx_data = data;
        tx_req  = 1'b1;
        repeat (4 * bit_clocks()) begin
            @(negedge clk);
            check_cond(!tx_ack, "tx_ack while enable low");
        end
        enable = 1'b1;
        while (!tx_ack)
            @(negedge clk);
        tx_req = 1'b0;
        wait_word(w);
        compare_word(w, data, 1'b0, 1'b0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/baud_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module baud_gen (
    input  logic                clk,
    input  logic                reset,
    input  uart_pkg::baud_sel_t baud_sel,   // Rate select from the host
    output logic                tick        // One-cycle pulse at 16x baud
);

    logic [15:0]         div;               // Divider for the current select
    logic [15:0]         count;             // Cycles left until next tick
    uart_pkg::baud_sel_t sel_q;             // Select seen last cycle

    // Every table entry fits in 16 bits
    assign div = 16'(uart_pkg::BAUD_DIV[baud_sel]);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
            sel_q <= '0;
            tick  <= 1'b0;
        end else begin
            sel_q <= baud_sel;              // Track select for change detect
            tick  <= 1'b0;                  // Default no pulse
            if (sel_q != baud_sel) begin
                // New rate restarts the period so the first tick is clean
                count <= div - 16'd1;
            end else if (count == 16'd0) begin
                count <= div - 16'd1;       // Reload for next period
                tick  <= 1'b1;              // Period expired
            end else begin
                count <= count - 16'd1;     // Count down
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // Ticks per bit on both serial directions
    localparam int unsigned OVERSAMPLE = 16;

    // Clock cycles per tick for each baud select value
    // Index 0 is the slowest rate and index 7 the fastest
    localparam int unsigned BAUD_DIV [8] = '{
        1302,                             // ~1200 baud at 25 MHz
        651,                              // ~2400 baud
        326,                              // ~4800 baud
        163,                              // ~9600 baud
        81,                               // ~19200 baud
        41,                               // ~38400 baud
        27,                               // ~57600 baud
        2                                 // Fast rate for simulation
    };

    typedef logic [2:0] baud_sel_t;       // Index into BAUD_DIV

    // Transmitter FSM states
    typedef enum logic [2:0] {
        TX_DISABLED,                      // Waits for enable after a frame
        TX_IDLE,                          // Ready for a host request
        TX_START_BIT,
        TX_DATA,                          // Eight data bits, MSB first
        TX_PARITY,                        // Even parity bit
        TX_STOP_BIT
    } tx_state_t;

    // Receiver FSM states
    typedef enum logic [2:0] {
        RX_IDLE,                          // Looking for a falling edge
        RX_START_BIT,                     // Checks the start bit midpoint
        RX_DATA,
        RX_PARITY,
        RX_STOP_BIT,
        RX_HOLD                           // Word offered to the host
    } rx_state_t;

    // Received word with its error flags
    typedef struct packed {
        logic [7:0] data;                 // Received byte
        logic       parity_err;           // Parity bit disagrees with data
        logic       frame_err;            // Stop bit sampled low
    } rx_word_t;

endpackage

`default_nettype wire

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic               clk,
    input  logic               reset,
    input  logic               tick,      // 16x baud strobe
    input  logic               rxd,       // Asynchronous serial input
    input  logic               rx_ack,    // Host acknowledge
    output logic               rx_req,    // Word available
    output uart_pkg::rx_word_t rx_word    // Byte and error flags
);

    uart_pkg::rx_state_t state;
    logic                rxd_meta;        // First synchronizer stage
    logic                rxd_sync;        // Synchronized line
    logic                rxd_prev;        // Previous synchronized value
    logic [3:0]          tick_cnt;        // Ticks since last sample point
    logic [3:0]          sample_at;       // Count that marks a bit midpoint
    logic [2:0]          bit_idx;         // Data bits received so far
    logic [7:0]          shreg;           // Data shift register
    logic                parity_q;        // Received parity bit
    logic                start_edge;      // High to low on the line
    logic                sample;          // Midpoint strobe

    assign start_edge = rxd_prev && !rxd_sync;

    // Half a bit to the start midpoint, then one full bit per sample
    assign sample_at = (state == uart_pkg::RX_START_BIT) ?
                       4'(uart_pkg::OVERSAMPLE / 2 - 1) :
                       4'(uart_pkg::OVERSAMPLE - 1);

    assign sample = tick && (tick_cnt == sample_at);

    // Two-flop synchronizer plus edge history
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxd_meta <= 1'b1;             // Line idles high
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // Receive FSM and handshake
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= uart_pkg::RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_req   <= 1'b0;
        end else begin
            if (state == uart_pkg::RX_IDLE || state == uart_pkg::RX_HOLD)
                tick_cnt <= '0;                   // Counter parked
            else if (sample)
                tick_cnt <= '0;                   // Measure from this midpoint
            else if (tick)
                tick_cnt <= tick_cnt + 4'd1;

            case (state)
                uart_pkg::RX_IDLE: begin
                    if (start_edge)
                        state <= uart_pkg::RX_START_BIT;
                end

                uart_pkg::RX_START_BIT: begin
                    if (sample) begin
                        if (rxd_sync) begin
                            state <= uart_pkg::RX_IDLE;   // Glitch, not a start bit
                        end else begin
                            state   <= uart_pkg::RX_DATA;
                            bit_idx <= 3'd0;
                        end
                    end
                end

                uart_pkg::RX_DATA: begin
                    if (sample) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= uart_pkg::RX_PARITY; // Eighth bit in
                    end
                end

                uart_pkg::RX_PARITY: begin
                    if (sample)
                        state <= uart_pkg::RX_STOP_BIT;
                end

                uart_pkg::RX_STOP_BIT: begin
                    if (sample) begin
                        state  <= uart_pkg::RX_HOLD;
                        rx_req <= 1'b1;           // Word valid next cycle
                    end
                end

                uart_pkg::RX_HOLD: begin
                    // Start bits arriving here are ignored
                    if (rx_req && rx_ack)
                        rx_req <= 1'b0;           // Host took the word
                    else if (!rx_req && !rx_ack)
                        state <= uart_pkg::RX_IDLE;   // Handshake closed
                end

                default: begin
                    state <= uart_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Data path, updated only at sample points
    always_ff @(posedge clk) begin
        if (sample && state == uart_pkg::RX_DATA)
            shreg <= {shreg[6:0], rxd_sync};      // MSB arrives first
        if (sample && state == uart_pkg::RX_PARITY)
            parity_q <= rxd_sync;
        if (sample && state == uart_pkg::RX_STOP_BIT) begin
            rx_word.data       <= shreg;
            rx_word.parity_err <= parity_q != ^shreg;   // Even parity check
            rx_word.frame_err  <= !rxd_sync;            // Stop bit must be 1
        end
    end

endmodule

`default_nettype wire

// ==== src/uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  logic                clk,
    input  logic                reset,
    input  uart_pkg::baud_sel_t baud_sel,   // Shared rate for both directions
    input  logic                enable,     // Transmit enable
    input  logic                tx_req,
    input  logic [7:0]          tx_data,
    output logic                tx_ack,
    output logic                txd,        // Serial out
    input  logic                rxd,        // Serial in
    output logic                rx_req,
    input  logic                rx_ack,
    output uart_pkg::rx_word_t  rx_word
);

    logic tick;                             // 16x strobe to both directions

    baud_gen baud_gen_inst (
        .clk      (clk),
        .reset    (reset),
        .baud_sel (baud_sel),
        .tick     (tick)
    );

    uart_tx uart_tx_inst (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .enable  (enable),
        .tx_req  (tx_req),
        .tx_data (tx_data),
        .tx_ack  (tx_ack),
        .txd     (txd)
    );

    uart_rx uart_rx_inst (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .rxd     (rxd),
        .rx_ack  (rx_ack),
        .rx_req  (rx_req),
        .rx_word (rx_word)
    );

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,        // 16x baud strobe
    input  logic       enable,      // Lets the FSM leave DISABLED
    input  logic       tx_req,      // Host request
    input  logic [7:0] tx_data,     // Byte to send, stable while tx_req
    output logic       tx_ack,      // Handshake acknowledge
    output logic       txd          // Serial line, idles high
);

    uart_pkg::tx_state_t state;
    logic [3:0]          tick_cnt;  // Ticks within the current bit
    logic [2:0]          bit_idx;   // Data bit on the line, counts down
    logic [7:0]          data_q;    // Latched byte
    logic                accept;    // Start of a new frame
    logic                bit_end;   // Last tick of a bit
    logic                line_bit;  // Level the line should carry

    // New request only once the previous handshake has closed
    assign accept = (state == uart_pkg::TX_IDLE) && enable && tx_req && !tx_ack;

    assign bit_end = tick && (tick_cnt == 4'(uart_pkg::OVERSAMPLE - 1));

    // Line level per state
    always_comb begin
        case (state)
            uart_pkg::TX_START_BIT: line_bit = 1'b0;            // Start bit
            uart_pkg::TX_DATA:      line_bit = data_q[bit_idx]; // MSB first
            uart_pkg::TX_PARITY:    line_bit = ^data_q;         // Even parity
            default:                line_bit = 1'b1;            // Stop and idle
        endcase
    end

    // Frame sequencing
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= uart_pkg::TX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            if (state == uart_pkg::TX_IDLE) begin
                tick_cnt <= '0;                     // Align count to frame start
            end else if (tick) begin
                tick_cnt <= tick_cnt + 4'd1;        // Wraps after 16 ticks
            end

            case (state)
                uart_pkg::TX_DISABLED: begin
                    if (enable)
                        state <= uart_pkg::TX_IDLE;
                end

                uart_pkg::TX_IDLE: begin
                    if (accept)
                        state <= uart_pkg::TX_START_BIT;
                end

                uart_pkg::TX_START_BIT: begin
                    if (bit_end) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_idx <= 3'd7;            // MSB goes first
                    end
                end

                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd0)
                            state <= uart_pkg::TX_PARITY;
                        else
                            bit_idx <= bit_idx - 3'd1;
                    end
                end

                uart_pkg::TX_PARITY: begin
                    if (bit_end)
                        state <= uart_pkg::TX_STOP_BIT;
                end

                uart_pkg::TX_STOP_BIT: begin
                    if (bit_end)
                        state <= uart_pkg::TX_DISABLED; // Wait for enable
                end

                default: begin
                    state <= uart_pkg::TX_DISABLED;     // Recover from bad encoding
                end
            endcase
        end
    end

    // Four-phase acknowledge
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            tx_ack <= 1'b0;
        else if (accept)
            tx_ack <= 1'b1;                         // Data taken
        else if (tx_ack && !tx_req)
            tx_ack <= 1'b0;                         // Host released request
    end

    // Byte capture
    always_ff @(posedge clk) begin
        if (accept)
            data_q <= tx_data;
    end

    // Line register updated only on a tick
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            txd <= 1'b1;
        else if (tick)
            txd <= line_bit;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/uart_pkg.sv
src/baud_gen.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
sim/uart_assert.sv
sim/uart_tb.sv
